// File: hw/fe_defs.svh
/* front end widths and constants */

`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// address and data path width
`define FE_XLEN 32

// one flag per interrupt source
`define FE_INT_W 8

// first fetch after reset
`define FE_RESET_PC 32'h0000_0000

// addi x0 x0 0 loaded into a flushed stage
`define FE_INST_NOP 32'h0000_0013

`endif

// File: hw/fe_pkg.sv
/* front end shared types */

`default_nettype none

`include "fe_defs.svh"

package fe_pkg;

    // pipeline stage control
    typedef enum logic [1:0] {
        PIPE_FLOW  = 2'd0,                  // stage advances
        PIPE_HOLD  = 2'd1,                  // stage keeps contents
        PIPE_CLEAR = 2'd2                   // stage flushed to nop
    } hold_e;

    // major opcode class
    typedef enum logic [3:0] {
        OP_LUI     = 4'd0,
        OP_AUIPC   = 4'd1,
        OP_JAL     = 4'd2,
        OP_JALR    = 4'd3,
        OP_BRANCH  = 4'd4,
        OP_LOAD    = 4'd5,
        OP_STORE   = 4'd6,
        OP_ALUI    = 4'd7,                  // reg-imm arithmetic
        OP_ALU     = 4'd8,                  // reg-reg arithmetic
        OP_FENCE   = 4'd9,
        OP_SYSTEM  = 4'd10,
        OP_ILLEGAL = 4'd15                  // unknown or compressed
    } op_e;

    // packet handed from decode to execute
    typedef struct packed {
        op_e                   op;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [`FE_XLEN-1:0]   imm;         // sign extended per format
        logic [`FE_XLEN-1:0]   pc;
        logic [`FE_XLEN-1:0]   pc_next;
        logic [`FE_INT_W-1:0]  irq;         // carried only, never taken
    } dec_t;

endpackage

`default_nettype wire

// File: hw/fe_top.sv
/* instruction front end */

`default_nettype none

`include "fe_defs.svh"

module fe_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    output logic [`FE_XLEN-1:0]  imem_addr_o,      // combinational memory
    input  logic [`FE_XLEN-1:0]  imem_rdata_i,
    input  logic                 redirect_valid_i,
    input  logic [`FE_XLEN-1:0]  redirect_pc_i,
    input  logic [`FE_INT_W-1:0] irq_i,
    output fe_pkg::dec_t         dec_o,
    output logic                 dec_valid_o,
    input  logic                 dec_ready_i
);

    import fe_pkg::*;

    hold_e                hold_flag;
    logic [`FE_XLEN-1:0]  pc;
    logic [`FE_XLEN-1:0]  pc_next;
    logic [`FE_INT_W-1:0] irq_pend;
    logic [`FE_XLEN-1:0]  id_inst;
    logic [`FE_XLEN-1:0]  id_addr;
    logic [`FE_XLEN-1:0]  id_addr_next;
    logic [`FE_INT_W-1:0] id_int;
    logic                 id_valid;

    pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .hold_flag_i   (hold_flag),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (pc),
        .pc_next_o     (pc_next)
    );

    assign imem_addr_o = pc;

    pipe_ctrl u_pipe_ctrl (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .redirect_valid_i (redirect_valid_i),
        .dec_valid_i      (dec_valid_o),    // back pressure loop
        .dec_ready_i      (dec_ready_i),
        .irq_i            (irq_i),
        .hold_flag_o      (hold_flag),
        .irq_pend_o       (irq_pend)
    );

    if_id u_if_id (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .inst_i           (imem_rdata_i),
        .inst_addr_i      (pc),
        .inst_addr_next_i (pc_next),
        .hold_flag_i      (hold_flag),
        .int_flag_i       (irq_pend),
        .inst_o           (id_inst),
        .inst_addr_o      (id_addr),
        .inst_addr_next_o (id_addr_next),
        .int_flag_o       (id_int),
        .valid_o          (id_valid)
    );

    id_decode u_id_decode (
        .inst_i           (id_inst),
        .inst_addr_i      (id_addr),
        .inst_addr_next_i (id_addr_next),
        .int_flag_i       (id_int),
        .valid_i          (id_valid),
        .dec_o            (dec_o),
        .dec_valid_o      (dec_valid_o)
    );

    // upper immediates never carry low bits
    a_upper_imm: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o && (dec_o.op == OP_LUI || dec_o.op == OP_AUIPC)
            |-> dec_o.imm[11:0] == 12'h000
    ) else $error("fe_top: u-type immediate %h has low bits set", dec_o.imm);

endmodule

`default_nettype wire

// File: hw/id_decode.sv
/* rv32i instruction decoder */

`default_nettype none

`include "fe_defs.svh"

module id_decode (
    input  logic [`FE_XLEN-1:0]  inst_i,
    input  logic [`FE_XLEN-1:0]  inst_addr_i,
    input  logic [`FE_XLEN-1:0]  inst_addr_next_i,
    input  logic [`FE_INT_W-1:0] int_flag_i,
    input  logic                 valid_i,
    output fe_pkg::dec_t         dec_o,
    output logic                 dec_valid_o
);

    import fe_pkg::*;

    op_e                 op;
    logic [`FE_XLEN-1:0] imm_i;
    logic [`FE_XLEN-1:0] imm_s;
    logic [`FE_XLEN-1:0] imm_b;
    logic [`FE_XLEN-1:0] imm_u;
    logic [`FE_XLEN-1:0] imm_j;
    logic [`FE_XLEN-1:0] imm;

    // major opcode class
    always_comb begin
        if (inst_i[1:0] != 2'b11) begin
            op = OP_ILLEGAL;                // compressed not supported
        end else begin
            case (inst_i[6:2])
                5'b01101: op = OP_LUI;
                5'b00101: op = OP_AUIPC;
                5'b11011: op = OP_JAL;
                5'b11001: op = OP_JALR;
                5'b11000: op = OP_BRANCH;
                5'b00000: op = OP_LOAD;
                5'b01000: op = OP_STORE;
                5'b00100: op = OP_ALUI;
                5'b01100: op = OP_ALU;
                5'b00011: op = OP_FENCE;
                5'b11100: op = OP_SYSTEM;
                default:  op = OP_ILLEGAL;
            endcase
        end
    end

    // immediates per format
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};   // halfword offset
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        case (op)
            OP_LUI, OP_AUIPC:                    imm = imm_u;
            OP_JAL:                              imm = imm_j;
            OP_BRANCH:                           imm = imm_b;
            OP_STORE:                            imm = imm_s;
            OP_JALR, OP_LOAD, OP_ALUI,
            OP_FENCE, OP_SYSTEM:                 imm = imm_i;
            default:                             imm = '0; // r format and illegal
        endcase
    end

    always_comb begin
        dec_o.op      = op;
        dec_o.funct3  = inst_i[14:12];
        dec_o.funct7  = inst_i[31:25];
        dec_o.rd      = inst_i[11:7];
        dec_o.rs1     = inst_i[19:15];
        dec_o.rs2     = inst_i[24:20];  // raw fields for every format
        dec_o.imm     = imm;
        dec_o.pc      = inst_addr_i;
        dec_o.pc_next = inst_addr_next_i;
        dec_o.irq     = int_flag_i;
    end

    assign dec_valid_o = valid_i;       // nop bubbles stay invalid

endmodule

`default_nettype wire

// File: hw/if_id.sv
/* fetch to decode pipeline register */

`default_nettype none

`include "fe_defs.svh"

module if_id (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [`FE_XLEN-1:0]  inst_i,           // word from imem
    input  logic [`FE_XLEN-1:0]  inst_addr_i,      // its address
    input  logic [`FE_XLEN-1:0]  inst_addr_next_i,
    input  fe_pkg::hold_e        hold_flag_i,
    input  logic [`FE_INT_W-1:0] int_flag_i,       // pending irqs
    output logic [`FE_XLEN-1:0]  inst_o,
    output logic [`FE_XLEN-1:0]  inst_addr_o,
    output logic [`FE_XLEN-1:0]  inst_addr_next_o,
    output logic [`FE_INT_W-1:0] int_flag_o,
    output logic                 valid_o           // stage holds a real fetch
);

    import fe_pkg::*;

    logic [`FE_XLEN-1:0]  inst_q;
    logic [`FE_XLEN-1:0]  addr_q;
    logic [`FE_XLEN-1:0]  addr_next_q;
    logic [`FE_INT_W-1:0] int_q;
    logic                 valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || hold_flag_i == PIPE_CLEAR) begin
            inst_q      <= `FE_INST_NOP;    // bubble
            addr_q      <= '0;
            addr_next_q <= '0;
            int_q       <= '0;
            valid_q     <= 1'b0;
        end else if (hold_flag_i == PIPE_FLOW) begin
            inst_q      <= inst_i;
            addr_q      <= inst_addr_i;
            addr_next_q <= inst_addr_next_i;
            int_q       <= int_flag_i;
            valid_q     <= 1'b1;            // memory answers every cycle
        end
    end

    assign inst_o           = inst_q;
    assign inst_addr_o      = addr_q;
    assign inst_addr_next_o = addr_next_q;
    assign int_flag_o       = int_q;
    assign valid_o          = valid_q;

    a_hold_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (hold_flag_i == PIPE_HOLD) |=>
            $stable({inst_o, inst_addr_o, inst_addr_next_o, int_flag_o, valid_o})
    ) else $error("if_id: contents changed across a hold");

endmodule

`default_nettype wire

// File: hw/pc_gen.sv
/* program counter generator */

`default_nettype none

`include "fe_defs.svh"

module pc_gen (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  fe_pkg::hold_e       hold_flag_i,    // from pipe_ctrl
    input  logic [`FE_XLEN-1:0] redirect_pc_i,  // branch or jump target
    output logic [`FE_XLEN-1:0] pc_o,           // fetch address
    output logic [`FE_XLEN-1:0] pc_next_o       // sequential successor
);

    import fe_pkg::*;

    localparam logic [`FE_XLEN-1:0] PC_STEP = `FE_XLEN'd4; // one word per fetch

    logic [`FE_XLEN-1:0] pc_q;
    logic [`FE_XLEN-1:0] pc_seq;

    assign pc_seq = pc_q + PC_STEP;         // no compressed support

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `FE_RESET_PC;
        end else begin
            case (hold_flag_i)
                PIPE_CLEAR: pc_q <= redirect_pc_i; // redirect wins
                PIPE_HOLD:  pc_q <= pc_q;          // stall refetches same word
                default:    pc_q <= pc_seq;
            endcase
        end
    end

    assign pc_o      = pc_q;
    assign pc_next_o = pc_seq;

    // redirect targets come from execute so alignment is checked here
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00
    ) else $error("pc_gen: fetch address %h not word aligned", pc_q);

endmodule

`default_nettype wire

// File: hw/pipe_ctrl.sv
/* pipeline hold and interrupt pending */

`default_nettype none

`include "fe_defs.svh"

module pipe_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 redirect_valid_i, // one cycle pulse from execute
    input  logic                 dec_valid_i,      // decode offering a packet
    input  logic                 dec_ready_i,      // downstream can take it
    input  logic [`FE_INT_W-1:0] irq_i,            // request pulses
    output fe_pkg::hold_e        hold_flag_o,
    output logic [`FE_INT_W-1:0] irq_pend_o        // into if_id
);

    import fe_pkg::*;

    hold_e               hold_flag;
    logic [`FE_INT_W-1:0] irq_pend_q;

    always_comb begin
        if (redirect_valid_i) begin
            hold_flag = PIPE_CLEAR;         // flush wrong path fetch
        end else if (dec_valid_i && !dec_ready_i) begin
            hold_flag = PIPE_HOLD;          // back pressure
        end else begin
            hold_flag = PIPE_FLOW;
        end
    end

    // sticky until a flow edge hands the bits to if_id
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            irq_pend_q <= '0;
        end else if (hold_flag == PIPE_FLOW) begin
            irq_pend_q <= irq_i;            // old bits leave with the fetch
        end else begin
            irq_pend_q <= irq_pend_q | irq_i; // kept over hold and clear
        end
    end

    assign hold_flag_o = hold_flag;
    assign irq_pend_o  = irq_pend_q;

    // a redirect flushes and decode offers nothing in the next cycle
    a_redirect_flush: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        redirect_valid_i |=> !dec_valid_i
    ) else $error("pipe_ctrl: redirect did not flush the decode stage");

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/fe_pkg.sv
hw/pc_gen.sv
hw/pipe_ctrl.sv
hw/if_id.sv
hw/id_decode.sv
hw/fe_top.sv
test/tb_clk.sv
test/fe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the front end testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module fe_tb -o fe_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/fe_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation ended with an error, see sim.log"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1

// File: test/fe_tb.sv
/* front end directed tests */

`default_nettype none

`include "fe_defs.svh"

module fe_tb;

    import fe_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic [`FE_XLEN-1:0]  imem_addr;
    logic [`FE_XLEN-1:0]  imem_rdata;
    logic                 redirect_valid;
    logic [`FE_XLEN-1:0]  redirect_pc;
    logic [`FE_INT_W-1:0] irq_in;
    dec_t                 dec_pkt;
    logic                 dec_valid;
    logic                 dec_ready;

    logic [31:0] imem [0:63];               // 64 words, no wait states
    logic [31:0] lfsr;
    dec_t        acc_q [$];                 // packets taken downstream
    dec_t        held_pkt;
    logic        stalled;
    logic        timed_out;
    string       test_name;
    int          test_errs;
    int          total_errs;
    int          tests_run;

    tb_clk u_clk (.clk_o(clk));

    fe_top dut_i (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .imem_addr_o      (imem_addr),
        .imem_rdata_i     (imem_rdata),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .irq_i            (irq_in),
        .dec_o            (dec_pkt),
        .dec_valid_o      (dec_valid),
        .dec_ready_i      (dec_ready)
    );

    assign imem_rdata = imem[imem_addr[7:2]];   // same cycle answer

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // rv32i format rules
    function automatic dec_t ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                        input logic [7:0] irq);
        dec_t d;
        d.funct3  = w[14:12];
        d.funct7  = w[31:25];
        d.rd      = w[11:7];
        d.rs1     = w[19:15];
        d.rs2     = w[24:20];
        d.pc      = pc;
        d.pc_next = pc + 32'd4;
        d.irq     = irq;
        case (w[6:0])                       // full opcode so low bits must be 11
            7'h37:   d.op = OP_LUI;
            7'h17:   d.op = OP_AUIPC;
            7'h6f:   d.op = OP_JAL;
            7'h67:   d.op = OP_JALR;
            7'h63:   d.op = OP_BRANCH;
            7'h03:   d.op = OP_LOAD;
            7'h23:   d.op = OP_STORE;
            7'h13:   d.op = OP_ALUI;
            7'h33:   d.op = OP_ALU;
            7'h0f:   d.op = OP_FENCE;
            7'h73:   d.op = OP_SYSTEM;
            default: d.op = OP_ILLEGAL;
        endcase
        case (d.op)
            OP_LUI, OP_AUIPC: d.imm = {w[31:12], 12'h000};
            OP_JAL:    d.imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'h0}) >>> 11;
            OP_BRANCH: d.imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'h0}) >>> 19;
            OP_STORE:  d.imm = $signed({w[31:25], w[11:7], 20'h0}) >>> 20;
            OP_ALU, OP_ILLEGAL: d.imm = '0;
            default:   d.imm = $signed(w) >>> 20;   // i format
        endcase
        return d;
    endfunction

    task automatic check_pkt(input string what, input dec_t exp, input dec_t act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_num(input string what, input int exp, input int act);
        assert (act == exp) else begin
            $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    // one cycle: drive after the edge, sample at the falling edge
    task automatic step(input logic rdy, input logic redir, input logic [31:0] tgt,
                        input logic [7:0] irq);
        @(posedge clk);
        #1;
        dec_ready      = rdy;
        redirect_valid = redir;
        redirect_pc    = tgt;
        irq_in         = irq;
        @(negedge clk);
        if (stalled && dec_valid) begin
            check_pkt("held packet", held_pkt, dec_pkt);
        end
        stalled  = dec_valid && !rdy && !redir;
        held_pkt = dec_pkt;
        if (dec_valid && rdy) begin
            acc_q.push_back(dec_pkt);       // transfers at the next edge
        end
    endtask

    task automatic collect(input int n, input bit rand_ready);
        int guard;
        guard = 0;
        while (acc_q.size() < n && !timed_out) begin
            step(rand_ready ? (take_bits(1) != 0) : 1'b1, 1'b0, '0, '0);
            guard++;
            if (guard > 20 * n + 40) begin
                $display("timeout in %s: only %0d of %0d packets accepted",
                         test_name, acc_q.size(), n);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst_n          = 1'b0;
        dec_ready      = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        irq_in         = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        stalled = 1'b0;
        acc_q.delete();
    endtask

    task automatic fill_random();
        for (int i = 0; i < 64; i++) begin
            imem[i] = take_bits(32);
        end
    endtask

    task automatic fill_pattern();
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0000_0013 | (32'(i) << 20);   // addi x0 x0 index
        end
    endtask

    // consecutive packets from base, each matching its memory word
    task automatic check_run(input int first, input int cnt, input logic [31:0] base,
                             input bit own_irq);
        logic [31:0] pc;
        dec_t        exp;
        for (int i = 0; i < cnt; i++) begin
            pc  = base + 32'(4 * i);
            exp = ref_decode(imem[pc[7:2]], pc, own_irq ? acc_q[first + i].irq : 8'h00);
            check_pkt($sformatf("packet %0d", first + i), exp, acc_q[first + i]);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
        tests_run++;
    endtask

    task automatic end_test();
        $display("%s: %0d packets, %0d checks failed", test_name, acc_q.size(), test_errs);
        total_errs += test_errs;
    endtask

    task automatic seq_fetch_test();
        begin_test("sequential fetch");
        fill_random();
        reset_dut();
        collect(24, 1'b0);
        check_run(0, acc_q.size(), 32'h0, 1'b0);
        end_test();
    endtask

    task automatic decode_test();
        op_e         want [0:13];
        logic [31:0] prog [0:13];
        want = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE,
                 OP_ALUI, OP_ALU, OP_FENCE, OP_SYSTEM, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL};
        prog = '{32'hfedcb2b7, 32'h00001517, 32'hff5ff0ef, 32'hffc50067,
                 32'hfe209ee3, 32'hff852283, 32'hfe552c23, 32'h80010113,
                 32'h40b50533, 32'h0ff0000f, 32'h00000073, 32'h00000000,
                 32'hfff00ffb, 32'h00a28291};  // unknown opcode, bad low bits
        begin_test("decode coverage");
        fill_pattern();
        for (int i = 0; i < 14; i++) begin
            imem[i] = prog[i];
        end
        reset_dut();
        collect(14, 1'b0);
        check_run(0, acc_q.size(), 32'h0, 1'b0);
        for (int i = 0; i < acc_q.size() && i < 14; i++) begin
            check_num($sformatf("op class %0d", i), int'(want[i]), int'(acc_q[i].op));
        end
        end_test();
    endtask

    task automatic backpressure_test();
        begin_test("back-pressure");
        fill_random();
        reset_dut();
        collect(40, 1'b1);                  // stability checked inside step
        check_run(0, acc_q.size(), 32'h0, 1'b0);
        end_test();
    endtask

    task automatic redirect_test();
        int pre;
        begin_test("redirect");
        fill_pattern();
        reset_dut();
        collect(6, 1'b1);
        step(1'b1, 1'b1, 32'h0000_00a0, '0);
        pre = acc_q.size();                 // taken up to the flush edge
        collect(pre + 12, 1'b1);
        check_run(0, pre, 32'h0, 1'b0);
        check_run(pre, acc_q.size() - pre, 32'h0000_00a0, 1'b0);
        end_test();
    endtask

    task automatic irq_test();
        logic [7:0] pulse;
        logic       rdy;
        int         hits;
        begin_test("interrupt carry");
        fill_random();
        reset_dut();
        for (int c = 0; c < 60; c++) begin
            pulse = (c % 6 == 3 && c / 6 < 8) ? 8'(1 << (c / 6)) : 8'h00;
            rdy   = (c % 12 == 3) ? 1'b0 : (take_bits(1) != 0);  // even bits hit a stall
            step(rdy, 1'b0, '0, pulse);     // stalls mixed in
        end
        collect(acc_q.size() + 8, 1'b0);    // drain pending flags
        check_run(0, acc_q.size(), 32'h0, 1'b1);
        for (int b = 0; b < 8; b++) begin
            hits = 0;
            foreach (acc_q[i]) begin
                if (acc_q[i].irq[b]) hits++;
            end
            check_num($sformatf("carriers of irq bit %0d", b), 1, hits);
        end
        end_test();
    endtask

    initial begin
        rst_n          = 1'b0;
        dec_ready      = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        irq_in         = '0;
        lfsr           = 32'h0d0eae1e;
        stalled        = 1'b0;
        timed_out      = 1'b0;
        total_errs     = 0;
        tests_run      = 0;
        if (!timed_out) seq_fetch_test();
        if (!timed_out) decode_test();
        if (!timed_out) backpressure_test();
        if (!timed_out) redirect_test();
        if (!timed_out) irq_test();
        $display("tests run %0d, checks failed %0d", tests_run, total_errs);
        if (total_errs == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clk.sv
/* testbench clock */

`default_nettype none

module tb_clk #(
    parameter int PERIOD = 4                // time units per cycle
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD / 2) clk_o = ~clk_o;    // rising edge every PERIOD

endmodule

`default_nettype wire
